/* Bender.yml */
package:
  name: decodeStage

sources:
  - logic/isaPkg.sv
  - logic/frontEndPkg.sv
  - logic/stageRegister.sv
  - logic/insnPredecoder.sv
  - logic/targetCalculator.sv
  - logic/returnAddressStack.sv
  - logic/branchResolver.sv
  - logic/decodeStage.sv
  - target: simulation
    files:
      - dv/decodeRefPkg.sv
      - dv/decodeStageTb.sv

/* decodeStage.f */
logic/isaPkg.sv
logic/frontEndPkg.sv
logic/stageRegister.sv
logic/insnPredecoder.sv
logic/targetCalculator.sv
logic/returnAddressStack.sv
logic/branchResolver.sv
logic/decodeStage.sv
dv/decodeRefPkg.sv
dv/decodeStageTb.sv

/* dv/decodeRefPkg.sv */
// Branch resolution reference model

package decodeRefPkg;

    localparam int MAX_DEPTH = 16;

    // Instruction classes seen by the scan
    localparam int CLS_PLAIN  = 0;
    localparam int CLS_BRANCH = 1;
    localparam int CLS_JAL    = 2;
    localparam int CLS_JALR   = 3;
    localparam int CLS_SERIAL = 4;

    frontEndPkg::addrType stackMem [MAX_DEPTH];
    int                   stackDepth;
    int                   stackTop;

    function automatic void resetModel(input int depth);
        stackDepth = depth;
        stackTop   = 0;
        for (int i = 0; i < MAX_DEPTH; i++) begin
            stackMem[i] = '0;
        end
    endfunction

    function automatic int classify(input logic [31:0] insn);
        case (insn[6:0])
            isaPkg::OPC_BRANCH:   return CLS_BRANCH;
            isaPkg::OPC_JAL:      return CLS_JAL;
            isaPkg::OPC_JALR:     return CLS_JALR;
            isaPkg::OPC_SYSTEM,
            isaPkg::OPC_MISC_MEM: return CLS_SERIAL;
            default:              return CLS_PLAIN;
        endcase
    endfunction

    function automatic bit isLink(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    // Next PC as the decoder should see it, stack top for any JALR
    function automatic frontEndPkg::addrType nextPc(input frontEndPkg::fetchLane lane);
        logic [31:0] w;
        w = lane.insn;
        case (classify(w))
            CLS_BRANCH: return lane.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            CLS_JAL:    return lane.pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            CLS_JALR:   return stackMem[stackTop];
            default:    return lane.pc + isaPkg::INSN_BYTES;
        endcase
    endfunction

    function automatic void resolve(input frontEndPkg::fetchLane group[$],
                                    output frontEndPkg::decodedLane result[$],
                                    output frontEndPkg::redirectInfo red);
        int                     checkIdx;
        int                     pushIdx;
        int                     cls;
        bit                     forced;
        bit                     doPush;
        bit                     doPop;
        bit                     done;
        bit                     flush;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        frontEndPkg::addrType   target;
        frontEndPkg::decodedLane lane;
        checkIdx = -1;
        pushIdx  = 0;
        forced   = 0;
        doPush   = 0;
        doPop    = 0;
        done     = 0;
        for (int i = 0; i < group.size() && !done; i++) begin
            cls  = classify(group[i].insn);
            rd   = group[i].insn[11:7];
            rs1  = group[i].insn[19:15];
            done = 1;
            if (!group[i].valid) begin
                checkIdx = checkIdx;
            end else if ((cls == CLS_PLAIN || cls == CLS_SERIAL) && group[i].predTaken) begin
                checkIdx = i;
                forced   = 1;
            end else if (cls == CLS_JAL || (cls == CLS_BRANCH && group[i].predTaken)) begin
                checkIdx = i;
                doPush   = (cls == CLS_JAL) && isLink(rd);
                pushIdx  = i;
            end else if (cls == CLS_JALR && isLink(rs1) && rd == 5'd0) begin
                checkIdx = i;
                doPop    = 1;
            end else if (cls == CLS_JALR && isLink(rd)) begin
                doPush  = 1;
                pushIdx = i;
            end else if (cls == CLS_SERIAL) begin
                checkIdx = i;
                forced   = 1;
            end else begin
                done = 0;
            end
        end
        target     = (checkIdx >= 0) ? nextPc(group[checkIdx]) : '0;
        flush      = forced || (checkIdx >= 0 && group[checkIdx].predAddr != target);
        red.flush  = flush;
        red.target = flush ? target : '0;
        result.delete();
        for (int i = 0; i < group.size(); i++) begin
            lane.pc              = group[i].pc;
            lane.insn            = group[i].insn;
            lane.flushed         = flush && (i > checkIdx);
            lane.flushTriggering = flush && (i == checkIdx);
            lane.valid           = group[i].valid && !lane.flushed;
            lane.predTaken       = lane.flushTriggering ? 1'b1 : group[i].predTaken;
            lane.predAddr        = lane.flushTriggering ? target : group[i].predAddr;
            result.push_back(lane);
        end
        // Stack moves after the group has read its top
        if (doPush) begin
            stackTop           = (stackTop + 1) % stackDepth;
            stackMem[stackTop] = group[pushIdx].pc + isaPkg::INSN_BYTES;
        end else if (doPop) begin
            stackTop = (stackTop + stackDepth - 1) % stackDepth;
        end
    endfunction

endpackage

/* dv/decodeStageTb.sv */
// Decode stage testbench

`timescale 1ns/1ns

module decodeStageTb;

    localparam int WIDTH        = 2;
    localparam int DEPTH        = 4;
    localparam int NUM_TESTS    = 6;
    localparam int TOTAL_GROUPS = 20 + 30 + 40 + 60 + 60 + 200;
    localparam int WATCHDOG_NS  = (TOTAL_GROUPS + 2 * NUM_TESTS + 20) * 100;

    typedef enum int {
        insnAlu, insnBranch, insnJal, insnCall, insnReturn, insnJalr, insnSystem, insnFence
    } insnKind;

    typedef enum int {modePass, modeForced, modePcRel, modeCallRet, modeStall, modeMixed} testMode;

    logic                                 clk;
    logic                                 rst;
    logic                                 stall;
    frontEndPkg::fetchLane   [WIDTH-1:0]  fetchGroup;
    frontEndPkg::decodedLane [WIDTH-1:0]  decodedGroup;
    frontEndPkg::redirectInfo             redirect;

    integer                               seed;
    string                                testName;
    int                                   checkCount;
    int                                   errorCount;
    int                                   testChecks;
    int                                   testErrors;
    int                                   nest;
    frontEndPkg::fetchLane   [WIDTH-1:0]  heldGroup;
    frontEndPkg::fetchLane   [WIDTH-1:0]  drivenGroup;
    bit                                   heldReal;
    bit                                   drivenReal;
    bit                                   prevStall;
    frontEndPkg::decodedLane [WIDTH-1:0]  snapGroup;
    frontEndPkg::redirectInfo             snapRedirect;

    decodeStage #(.DECODE_WIDTH(WIDTH), .RAS_DEPTH(DEPTH)) dut (
        .clk(clk), .rst(rst), .stall(stall), .fetchGroup(fetchGroup),
        .decodedGroup(decodedGroup), .redirect(redirect)
    );

    always #50 clk = ~clk;

    task automatic compareValue(input string what, input logic [127:0] expected,
                                input logic [127:0] actual);
        checkCount++;
        testChecks++;
        if (expected !== actual) begin
            errorCount++;
            testErrors++;
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic makeLane(input testMode mode, input int lane, input frontEndPkg::addrType pc,
                            output frontEndPkg::fetchLane l);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  link;
        insnKind     kind;
        r    = $random(seed);
        s    = $random(seed);
        link = r[3] ? isaPkg::REG_T0 : isaPkg::REG_RA;
        case (mode)
            modePass:   kind = insnAlu;
            modeForced: kind = s[1] ? insnAlu : (s[0] ? insnSystem : insnFence);
            modePcRel:  kind = s[0] ? insnJal : insnBranch;
            modeCallRet: begin
                // Nest past the stack depth so the pointer wraps
                if (lane > 0) begin
                    kind = insnAlu;
                end else if (nest < 6 && s[0]) begin
                    kind = insnCall;
                end else begin
                    kind = insnReturn;
                end
            end
            default:    kind = insnKind'(s[2:0]);
        endcase
        if (kind == insnCall) begin
            nest++;
        end
        if (kind == insnReturn && nest > 0) begin
            nest--;
        end
        case (kind)
            insnAlu:    l.insn = {r[31:7], 7'b0010011};
            insnBranch: l.insn = {r[31:7], isaPkg::OPC_BRANCH};
            insnJal:    l.insn = {r[31:12], r[4] ? link : r[11:7], isaPkg::OPC_JAL};
            insnCall:   l.insn = r[4] ? {r[31:12], link, isaPkg::OPC_JAL}
                                      : {r[31:15], 3'b000, link, isaPkg::OPC_JALR};
            insnReturn: l.insn = {r[31:20], link, 3'b000, isaPkg::REG_ZERO, isaPkg::OPC_JALR};
            insnJalr:   l.insn = {r[31:15], 3'b000, r[11:7], isaPkg::OPC_JALR};
            insnSystem: l.insn = {r[31:7], isaPkg::OPC_SYSTEM};
            default:    l.insn = {r[31:7], isaPkg::OPC_MISC_MEM};
        endcase
        l.valid     = (mode != modeMixed && mode != modeStall) || (s[7:4] != 4'd0);
        l.pc        = pc;
        l.predTaken = (mode == modePass) ? 1'b0 : s[8];
        // Half the predictions carry the right address
        l.predAddr  = s[9] ? decodeRefPkg::nextPc(l) : ($random(seed) & 32'hffff_fffc);
    endtask

    // Checks what the last edge produced and then drives the next inputs
    task automatic advance(input frontEndPkg::fetchLane [WIDTH-1:0] group, input bit isReal,
                           input bit stallNext);
        frontEndPkg::fetchLane    groupQ[$];
        frontEndPkg::decodedLane  expLanes[$];
        frontEndPkg::redirectInfo expRedirect;
        @(posedge clk);
        #10;
        if (!prevStall) begin
            if (heldReal) begin
                for (int i = 0; i < WIDTH; i++) begin
                    groupQ.push_back(heldGroup[i]);
                end
                decodeRefPkg::resolve(groupQ, expLanes, expRedirect);
                for (int i = 0; i < WIDTH; i++) begin
                    compareValue($sformatf("lane %0d", i), expLanes[i], decodedGroup[i]);
                end
                compareValue("redirect flush", expRedirect.flush, redirect.flush);
                if (expRedirect.flush) begin
                    compareValue("redirect target", expRedirect.target, redirect.target);
                end
            end
            heldGroup    = drivenGroup;
            heldReal     = drivenReal;
            snapGroup    = decodedGroup;
            snapRedirect = redirect;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                compareValue($sformatf("stalled lane %0d", i), snapGroup[i], decodedGroup[i]);
            end
            compareValue("stalled redirect", snapRedirect, redirect);
        end
        fetchGroup  = group;
        stall       = stallNext;
        drivenGroup = group;
        drivenReal  = isReal;
        prevStall   = stallNext;
    endtask

    task automatic runTest(input string name, input testMode mode, input int count);
        frontEndPkg::fetchLane [WIDTH-1:0] group;
        frontEndPkg::addrType              base;
        logic [31:0]                       r;
        testName   = name;
        testChecks = 0;
        testErrors = 0;
        repeat (count) begin
            base = $random(seed) & 32'h000f_fffc;
            for (int i = 0; i < WIDTH; i++) begin
                makeLane(mode, i, base + 4 * i, group[i]);
            end
            r = $random(seed);
            advance(group, 1'b1, (mode == modeStall) && (r[1:0] == 2'd0));
        end
        // Two idle edges drain the last group
        advance('0, 1'b0, 1'b0);
        advance('0, 1'b0, 1'b0);
        $display("test %s: %0d checks, %0d mismatches", name, testChecks, testErrors);
    endtask

    initial begin
        seed         = 83789;
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        fetchGroup   = '0;
        checkCount   = 0;
        errorCount   = 0;
        nest         = 0;
        heldGroup    = '0;
        drivenGroup  = '0;
        heldReal     = 1'b0;
        drivenReal   = 1'b0;
        prevStall    = 1'b0;
        snapGroup    = '0;
        snapRedirect = '0;
        decodeRefPkg::resetModel(DEPTH);
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        runTest("passThrough", modePass, 20);
        runTest("forcedFlush", modeForced, 30);
        runTest("pcRelative", modePcRel, 40);
        runTest("callReturn", modeCallRet, 60);
        runTest("stallHold", modeStall, 60);
        runTest("randomMix", modeMixed, 200);
        $display("summary: %0d tests, %0d checks, %0d mismatches",
                 NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Bounded by the total number of groups plus drain and reset cycles
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the last test completed");
        $display("tests failed");
        $finish;
    end

endmodule

/* logic/branchResolver.sv */
// Branch resolution control

`timescale 1ns/1ns

module branchResolver #(
    parameter int DECODE_WIDTH = 2
) (
    input  frontEndPkg::fetchLane     [DECODE_WIDTH-1:0] lanes,
    input  frontEndPkg::predecodeInfo [DECODE_WIDTH-1:0] info,
    input  frontEndPkg::addrType      [DECODE_WIDTH-1:0] decodedPc,
    output frontEndPkg::decodedLane   [DECODE_WIDTH-1:0] outLanes,
    output frontEndPkg::redirectInfo                     redirect,
    output logic                                         push,
    output logic                                         pop,
    output frontEndPkg::addrType                         pushAddr
);

    localparam int LANE_BITS = (DECODE_WIDTH > 1) ? $clog2(DECODE_WIDTH) : 1;

    logic                    check;
    logic                    forced;
    logic                    done;
    logic                    flush;
    logic [LANE_BITS-1:0]    checkLane;
    logic [DECODE_WIDTH-1:0] triggerMask;
    logic [DECODE_WIDTH-1:0] validMask;

    // Scan from lane 0 up to the first lane that decides the group
    always_comb begin
        check     = 1'b0;
        forced    = 1'b0;
        done      = 1'b0;
        push      = 1'b0;
        pop       = 1'b0;
        checkLane = '0;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            if (!done) begin
                if (!lanes[i].valid) begin
                    done = 1'b1;
                end else if (!info[i].writesPc && lanes[i].predTaken) begin
                    // Taken prediction on a non-jump is always wrong
                    check     = 1'b1;
                    forced    = 1'b1;
                    checkLane = LANE_BITS'(i);
                    done      = 1'b1;
                end else if (info[i].kind == frontEndPkg::kindPcRelative &&
                             (info[i].isJal || lanes[i].predTaken)) begin
                    push      = info[i].isCall;
                    check     = 1'b1;
                    checkLane = LANE_BITS'(i);
                    done      = 1'b1;
                end else if (info[i].kind == frontEndPkg::kindIndirect) begin
                    if (info[i].isReturn) begin
                        pop       = 1'b1;
                        check     = 1'b1;
                        checkLane = LANE_BITS'(i);
                        done      = 1'b1;
                    end else if (info[i].isCall) begin
                        // Target unknown here so only the link is recorded
                        push      = 1'b1;
                        checkLane = LANE_BITS'(i);
                        done      = 1'b1;
                    end
                end else if (info[i].kind == frontEndPkg::kindSerialized) begin
                    check     = 1'b1;
                    forced    = 1'b1;
                    checkLane = LANE_BITS'(i);
                    done      = 1'b1;
                end
            end
        end
    end

    assign flush = forced ||
                   (check && (lanes[checkLane].predAddr != decodedPc[checkLane]));

    assign pushAddr = lanes[checkLane].pc +
                      frontEndPkg::addrType'(isaPkg::INSN_BYTES);

    assign redirect.flush  = flush;
    assign redirect.target = decodedPc[checkLane];

    // Correct the trigger lane and squash everything after it
    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            outLanes[i].pc              = lanes[i].pc;
            outLanes[i].insn            = lanes[i].insn;
            outLanes[i].flushTriggering = flush && (i == checkLane);
            outLanes[i].flushed         = flush && (i > checkLane);
            outLanes[i].valid           = lanes[i].valid && !outLanes[i].flushed;
            if (outLanes[i].flushTriggering) begin
                outLanes[i].predTaken = 1'b1;
                outLanes[i].predAddr  = decodedPc[i];
            end else begin
                outLanes[i].predTaken = lanes[i].predTaken;
                outLanes[i].predAddr  = lanes[i].predAddr;
            end
        end
    end

    for (genvar i = 0; i < DECODE_WIDTH; i++) begin : gMask
        assign triggerMask[i] = outLanes[i].flushTriggering;
        assign validMask[i]   = lanes[i].valid;
    end

    // Next stage restarts from a single valid lane
    singleTrigger: assert final ($onehot0(triggerMask) &&
                                 ((triggerMask & ~validMask) == '0))
        else $error("flush triggered by more than one lane or by an invalid lane");

endmodule

/* logic/decodeStage.sv */
// Decode stage branch resolution

`timescale 1ns/1ns

module decodeStage #(
    parameter int DECODE_WIDTH = 2,
    parameter int RAS_DEPTH    = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       stall,
    input  frontEndPkg::fetchLane   [DECODE_WIDTH-1:0] fetchGroup,
    output frontEndPkg::decodedLane [DECODE_WIDTH-1:0] decodedGroup,
    output frontEndPkg::redirectInfo                   redirect
);

    typedef frontEndPkg::fetchLane [DECODE_WIDTH-1:0] fetchGroupType;

    typedef struct packed {
        frontEndPkg::decodedLane [DECODE_WIDTH-1:0] lanes;
        frontEndPkg::redirectInfo                   redirect;
    } resultType;

    fetchGroupType                                 lanes;
    frontEndPkg::predecodeInfo [DECODE_WIDTH-1:0] info;
    frontEndPkg::addrType      [DECODE_WIDTH-1:0] decodedPc;
    frontEndPkg::addrType                          rasTop;
    frontEndPkg::addrType                          pushAddr;
    logic                                          push;
    logic                                          pop;
    resultType                                     resultD;
    resultType                                     resultQ;

    stageRegister #(.payloadType(fetchGroupType)) inputReg (
        .clk(clk), .rst(rst), .stall(stall), .d(fetchGroup), .q(lanes)
    );

    insnPredecoder #(.DECODE_WIDTH(DECODE_WIDTH)) predecoder (
        .lanes(lanes), .info(info)
    );

    targetCalculator #(.DECODE_WIDTH(DECODE_WIDTH)) targetCalc (
        .lanes(lanes), .info(info), .rasTop(rasTop), .decodedPc(decodedPc)
    );

    branchResolver #(.DECODE_WIDTH(DECODE_WIDTH)) resolver (
        .lanes(lanes), .info(info), .decodedPc(decodedPc),
        .outLanes(resultD.lanes), .redirect(resultD.redirect),
        .push(push), .pop(pop), .pushAddr(pushAddr)
    );

    // Advances together with the output register
    returnAddressStack #(.RAS_DEPTH(RAS_DEPTH)) ras (
        .clk(clk), .rst(rst), .stall(stall),
        .push(push), .pop(pop), .pushAddr(pushAddr), .top(rasTop)
    );

    stageRegister #(.payloadType(resultType)) outputReg (
        .clk(clk), .rst(rst), .stall(stall), .d(resultD), .q(resultQ)
    );

    assign decodedGroup = resultQ.lanes;
    assign redirect     = resultQ.redirect;

endmodule

/* logic/frontEndPkg.sv */
// Front-end lane and redirect types

package frontEndPkg;

    typedef logic [isaPkg::ADDR_WIDTH-1:0] addrType;

    // One fetch slot as delivered by the fetch stage
    typedef struct packed {
        logic        valid;
        addrType     pc;
        logic [31:0] insn;
        logic        predTaken;
        addrType     predAddr;
    } fetchLane;

    // Where the decoded next PC of a lane comes from
    typedef enum logic [1:0] {
        kindNext       = 2'd0,
        kindPcRelative = 2'd1,
        kindIndirect   = 2'd2,
        kindSerialized = 2'd3
    } branchKind;

    typedef struct packed {
        branchKind   kind;
        logic        isJal;
        logic        isCall;
        logic        isReturn;
        logic        writesPc;
        logic [31:0] offset;
    } predecodeInfo;

    // Lane as handed to the next stage
    typedef struct packed {
        logic        valid;
        logic        flushed;
        logic        flushTriggering;
        addrType     pc;
        logic [31:0] insn;
        logic        predTaken;
        addrType     predAddr;
    } decodedLane;

    typedef struct packed {
        logic    flush;
        addrType target;
    } redirectInfo;

endpackage

/* logic/insnPredecoder.sv */
// Instruction predecoder

`timescale 1ns/1ns

module insnPredecoder #(
    parameter int DECODE_WIDTH = 2
) (
    input  frontEndPkg::fetchLane     [DECODE_WIDTH-1:0] lanes,
    output frontEndPkg::predecodeInfo [DECODE_WIDTH-1:0] info
);

    for (genvar i = 0; i < DECODE_WIDTH; i++) begin : gLane
        logic [31:0] insn;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic        isJalr;
        logic        rdLink;
        logic        rs1Link;
        logic [31:0] branchOffset;
        logic [31:0] jalOffset;

        assign insn   = lanes[i].insn;
        assign opcode = insn[6:0];
        assign rd     = insn[11:7];
        assign rs1    = insn[19:15];
        assign isJalr = (opcode == isaPkg::OPC_JALR);

        // x1 and x5 both act as link registers
        assign rdLink  = (rd == isaPkg::REG_RA) || (rd == isaPkg::REG_T0);
        assign rs1Link = (rs1 == isaPkg::REG_RA) || (rs1 == isaPkg::REG_T0);

        // B-type immediate
        assign branchOffset = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

        // J-type immediate
        assign jalOffset = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

        always_comb begin
            info[i] = '0;
            case (opcode)
                isaPkg::OPC_BRANCH: begin
                    info[i].kind   = frontEndPkg::kindPcRelative;
                    info[i].offset = branchOffset;
                end
                isaPkg::OPC_JAL: begin
                    info[i].kind   = frontEndPkg::kindPcRelative;
                    info[i].offset = jalOffset;
                end
                isaPkg::OPC_JALR: begin
                    info[i].kind = frontEndPkg::kindIndirect;
                end
                isaPkg::OPC_SYSTEM,
                isaPkg::OPC_MISC_MEM: begin
                    info[i].kind = frontEndPkg::kindSerialized;
                end
                default: begin
                    info[i].kind = frontEndPkg::kindNext;
                end
            endcase

            info[i].isJal    = (opcode == isaPkg::OPC_JAL);
            info[i].writesPc = (info[i].kind == frontEndPkg::kindPcRelative) ||
                               (info[i].kind == frontEndPkg::kindIndirect);

            // Only jumps link, a branch has immediate bits in the rd field
            info[i].isCall   = (info[i].isJal || isJalr) && rdLink;
            info[i].isReturn = isJalr && rs1Link && (rd == isaPkg::REG_ZERO);
        end
    end

endmodule

/* logic/isaPkg.sv */
// RISC-V ISA constants

package isaPkg;

    // Program counter width
    localparam int ADDR_WIDTH = 32;

    // All instructions handled here are uncompressed
    localparam int INSN_BYTES = 4;

    // Major opcodes, bits [6:0] of the instruction word
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    // Register numbers used by the calling convention
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_T0   = 5'd5;

endpackage

/* logic/returnAddressStack.sv */
// Circular return address stack

`timescale 1ns/1ns

module returnAddressStack #(
    parameter int RAS_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 push,
    input  logic                 pop,
    input  frontEndPkg::addrType pushAddr,
    output frontEndPkg::addrType top
);

    // Depth of at least two, pointer wraps naturally
    localparam int PTR_BITS = $clog2(RAS_DEPTH);

    frontEndPkg::addrType entries [RAS_DEPTH];
    logic [PTR_BITS-1:0]  topPtr;
    logic [PTR_BITS-1:0]  abovePtr;

    assign abovePtr = topPtr + 1'b1;
    assign top      = entries[topPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                entries[i] <= '0;
            end
            topPtr <= '0;
        end else if (!stall) begin
            if (push) begin
                entries[abovePtr] <= pushAddr;
                topPtr            <= abovePtr;
            end else if (pop) begin
                topPtr <= topPtr - 1'b1;
            end
        end
    end

    // Resolver stops scanning at the first call or return
    pushPopExclusive: assert property (@(posedge clk) disable iff (rst) !(push && pop))
        else $error("stack push and pop in the same cycle");

endmodule

/* logic/stageRegister.sv */
// Stallable pipeline register

`timescale 1ns/1ns

module stageRegister #(
    parameter type payloadType = logic
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  payloadType d,
    output payloadType q
);

    // Clears to all zeros, so every valid bit and flush flag drops
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* logic/targetCalculator.sv */
// Decoded next PC per lane

`timescale 1ns/1ns

module targetCalculator #(
    parameter int DECODE_WIDTH = 2
) (
    input  frontEndPkg::fetchLane     [DECODE_WIDTH-1:0] lanes,
    input  frontEndPkg::predecodeInfo [DECODE_WIDTH-1:0] info,
    input  frontEndPkg::addrType                         rasTop,
    output frontEndPkg::addrType      [DECODE_WIDTH-1:0] decodedPc
);

    for (genvar i = 0; i < DECODE_WIDTH; i++) begin : gLane
        always_comb begin
            case (info[i].kind)
                frontEndPkg::kindPcRelative: begin
                    decodedPc[i] = lanes[i].pc + info[i].offset;
                end
                // Every indirect jump takes the stack top as its guess
                frontEndPkg::kindIndirect: begin
                    decodedPc[i] = rasTop;
                end
                default: begin
                    decodedPc[i] = lanes[i].pc +
                                   frontEndPkg::addrType'(isaPkg::INSN_BYTES);
                end
            endcase
        end
    end

endmodule
